/* badline_detect.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module badline_detect import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  raster_pos_t pos,
   input  vic_ctrl_t   ctrl,
   output logic        ba_req
);

   // set when den was seen on the first display line, held for the frame
   logic allow_bad_lines;
   logic in_window;
   logic badline;
   logic in_fetch_cycles;
   logic [`RASTER_X_W-4:0] cyc;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else begin
         // den on any clock of line 48 opens the frame for bad lines
         if (pos.line == `RASTER_Y_W'(`BADLINE_FIRST) && ctrl.den)
            allow_bad_lines <= 1'b1;
         // closes at the bottom of the display window
         if (pos.line == `RASTER_Y_W'(`BADLINE_LAST))
            allow_bad_lines <= 1'b0;
      end
   end

   // lines 48..247
   assign in_window = (pos.line >= `RASTER_Y_W'(`BADLINE_FIRST)) &&
                      (pos.line <  `RASTER_Y_W'(`BADLINE_LAST));

   // bad line when the low line bits hit yscroll inside the window
   assign badline = allow_bad_lines && in_window &&
                    (pos.line[2:0] == ctrl.yscroll);

   assign cyc = cycle_num(pos);

   // ba drops three cycles before the first c-access
   // and stays low through the last one
   assign in_fetch_cycles = (cyc >= 7'(`CHARS_BA_FIRST_CYCLE)) &&
                            (cyc <= 7'(`CHARS_BA_LAST_CYCLE));

   // active low request
   assign ba_req = !(badline && in_fetch_cycles);

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module bus_arbiter (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic clk_phi,
   input  logic phi_end,
   input  logic ba_req,
   input  logic ce,
   input  logic rw,
   output logic ba,
   output logic aec,
   output logic vic_write_db,
   output logic vic_write_ab,
   output logic ls245_data_dir
);

   localparam int N = `AEC_GRACE_PHASES;

   // ba history, stage i stays high until ba has been low for i+1 phi_end strobes
   // a high ba refills every stage at once
   logic [N-1:0] ba_hist;

   // cpu sees the request directly
   assign ba = ba_req;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba_hist <= '1;
      end else if (phi_end) begin
         ba_hist[0] <= ba_req;
         for (int i = 1; i < N; i++)
            ba_hist[i] <= ba_hist[i-1] | ba_req;
      end
   end

   // cpu owns the bus in phi high, vic in phi low
   // after the grace phases the vic keeps phi high too
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         aec <= 1'b0;
      else
         aec <= clk_phi & (ba_req | ba_hist[N-1]);
   end

   // drive the data bus when the cpu reads a register from us
   assign vic_write_db = aec && rw && !ce;

   // aec low means the vic owns the address bus
   assign vic_write_ab = !aec;

   // ls245 dir low points the buffer towards the cpu side
   assign ls245_data_dir = !vic_write_db;

endmodule

/* host_regs.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module host_regs import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        phi_end,
   input  logic        ce,
   input  logic        rw,
   input  logic [5:0]  adi,
   input  logic [7:0]  dbi,
   input  raster_pos_t pos,
   input  irq_state_t  irq_st,
   output vic_ctrl_t   ctrl,
   output logic        irst_clr,
   output logic [7:0]  dbo
);

   logic       wr_strobe;
   logic       rd_active;
   logic [7:0] rd_data;

   // cpu writes land at the end of its phi-high phase
   assign wr_strobe = phi_end && !ce && !rw;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl <= '0;
      end else if (wr_strobe) begin
         case (adi)
            `REG_CTRL1: begin
               ctrl.yscroll       <= dbi[2:0];
               ctrl.den           <= dbi[4];
               // bit 7 is the compare line msb
               ctrl.raster_cmp[8] <= dbi[7];
            end
            `REG_RASTER: begin
               ctrl.raster_cmp[7:0] <= dbi;
            end
            `REG_IRQ_ENABLE: begin
               ctrl.erst <= dbi[0];
            end
            default: begin
               ctrl <= ctrl;
            end
         endcase
      end
   end

   // writing 1 to status bit 0 acknowledges the raster irq
   // applied to the latch on the same clock as the write
   assign irst_clr = wr_strobe && (adi == `REG_IRQ_STATUS) && dbi[0];

   // unused bits float high on the real chip
   always_comb begin
      case (adi)
         `REG_CTRL1:
            rd_data = {pos.line[8], 2'b11, ctrl.den, 1'b1, ctrl.yscroll};
         `REG_RASTER:
            rd_data = pos.line[7:0];
         `REG_IRQ_STATUS:
            rd_data = {irq_st.irq, 6'h3f, irq_st.irst};
         `REG_IRQ_ENABLE:
            rd_data = {7'h7f, ctrl.erst};
         default:
            rd_data = 8'hff;
      endcase
   end

   assign rd_active = !ce && rw;

   // registered read data, idle bus reads all ones
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         dbo <= 8'hff;
      else
         dbo <= rd_active ? rd_data : 8'hff;
   end

endmodule

/* raster_irq.sv */
`timescale 1ns/1ps

module raster_irq import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  raster_pos_t pos,
   input  vic_ctrl_t   ctrl,
   input  logic        irst_clr,
   output irq_state_t  irq_st
);

   // compare matched on the previous clock of this line
   logic matched;
   logic line_match;
   logic trigger;
   logic irst_q;
   logic irst_next;
   logic irq_q;

   assign line_match = (pos.line == ctrl.raster_cmp);

   // only the first matching clock of a line fires
   assign trigger = line_match && !matched;

   // a host clear beats a trigger on the same clock
   always_comb begin
      if (irst_clr)
         irst_next = 1'b0;
      else
         irst_next = irst_q | trigger;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         matched <= 1'b0;
         irst_q  <= 1'b0;
         irq_q   <= 1'b0;
      end else begin
         // drops again once the line moves off the compare value
         matched <= line_match;
         irst_q  <= irst_next;
         // latch still sets with erst clear, so enabling later fires at once
         irq_q   <= irst_next & ctrl.erst;
      end
   end

   assign irq_st.irst = irst_q;
   assign irq_st.irq  = irq_q;

endmodule

/* raster_timing.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module raster_timing import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  chip_type    chip,
   output raster_pos_t pos,
   output logic        clk_phi,
   output logic        phi_end
);

   localparam int TICK_W = $clog2(`TICKS_PER_DOT);

   // per-chip limits
   logic [`RASTER_X_W-1:0] x_max;
   logic [`RASTER_Y_W-1:0] line_max;

   // dot4x ticks within the current pixel
   logic [TICK_W-1:0] tick;
   logic              last_tick;

   logic [`RASTER_X_W-1:0] x_next;
   logic [`RASTER_Y_W-1:0] line_next;

   // ntsc parts have longer lines, pal has more lines
   always_comb begin
      case (chip)
         CHIP6567R8: begin
            // 520 pixels, 263 lines
            x_max    = 10'd519;
            line_max = 9'd262;
         end
         CHIP6567R56A: begin
            // 512 pixels, 262 lines
            x_max    = 10'd511;
            line_max = 9'd261;
         end
         default: begin
            // 504 pixels, 312 lines
            x_max    = 10'd503;
            line_max = 9'd311;
         end
      endcase
   end

   assign last_tick = (tick == TICK_W'(`TICKS_PER_DOT - 1));

   // next beam position, only applied on the last tick of a pixel
   always_comb begin
      x_next    = pos.x;
      line_next = pos.line;
      if (pos.x >= x_max) begin
         x_next = '0;
         // end of line carries into the line counter
         if (pos.line >= line_max)
            line_next = '0;
         else
            line_next = pos.line + 1'b1;
      end else begin
         x_next = pos.x + 1'b1;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tick     <= '0;
         pos      <= '0;
         clk_phi  <= 1'b0;
      end else begin
         tick <= last_tick ? '0 : tick + 1'b1;
         if (last_tick) begin
            pos.x    <= x_next;
            pos.line <= line_next;
            // phi follows bit 2 of x, high for pixels 4..7 of each cycle
            clk_phi  <= x_next[2];
         end
      end
   end

   // last tick of pixel 7 closes the phi-high phase
   assign phi_end = last_tick && (pos.x[2:0] == 3'd7);

endmodule

/* tb_vic_core.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module tb_vic_core import vic_pkg::*; ();

   // 6567R56A geometry
   localparam int LINE_PIXELS  = 512;
   localparam int FRAME_LINES  = 262;
   localparam int PHI_CLOCKS   = 8 * `TICKS_PER_DOT;
   localparam int FRAME_CLOCKS = LINE_PIXELS * FRAME_LINES * `TICKS_PER_DOT;
   // one frame with den set, then 64 lines of the next frame with den clear
   localparam int PLAN_CLOCKS  = FRAME_CLOCKS + 64 * LINE_PIXELS * `TICKS_PER_DOT;
   localparam int LIMIT_CLOCKS = PLAN_CLOCKS * 6 / 5;

   logic                   clk_dot4x;
   logic                   rst;
   chip_type               chip;
   logic [5:0]             adi;
   logic [7:0]             dbi;
   logic                   ce;
   logic                   rw;
   logic                   clk_phi;
   logic [`RASTER_X_W-1:0] raster_x;
   logic [`RASTER_Y_W-1:0] raster_line;
   logic [7:0]             dbo;
   logic                   irq;
   logic                   ba;
   logic                   aec;
   logic                   vic_write_db;
   logic                   vic_write_ab;
   logic                   ls245_data_dir;

   logic [31:0] seed = 32'h6ca6_f534;
   int          cyc_cnt = 0;
   int          ba_lo0 = 0;
   int          ba_lo1 = 0;

   // reference model state
   // n counts clocks since reset
   int         n;
   logic       started = 1'b0;
   logic [2:0] m_ysc;
   logic       m_den;
   logic [8:0] m_cmp;
   logic       m_erst;
   logic       m_matched;
   logic       m_irst;
   logic       m_irq;
   logic       m_allow;
   int         m_lowcnt;
   logic       m_aec;
   logic [7:0] m_dbo;

   vic_core UUT (.*);

   bind vic_core vic_core_asserts u_asserts (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .clk_phi     (clk_phi),
      .aec         (aec),
      .ba          (ba),
      .raster_line (raster_line),
      .irq         (irq),
      .erst        (ctrl.erst)
   );

   always #20 clk_dot4x = ~clk_dot4x;

   function automatic logic [31:0] next_rand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   // pixel and line from the clock count
   function automatic int exp_x();
      return (n / `TICKS_PER_DOT) % LINE_PIXELS;
   endfunction

   function automatic int exp_line();
      return (n / `TICKS_PER_DOT / LINE_PIXELS) % FRAME_LINES;
   endfunction

   function automatic logic exp_ba();
      int  line;
      int  cyc;
      logic bad;
      line = exp_line();
      cyc  = exp_x() / 8;
      bad  = m_allow && line >= `BADLINE_FIRST && line < `BADLINE_LAST &&
             (line % 8) == m_ysc;
      return !(bad && cyc >= `CHARS_BA_FIRST_CYCLE && cyc <= `CHARS_BA_LAST_CYCLE);
   endfunction

   // expected register readback with unlisted bits at 1
   function automatic logic [7:0] read_model(input logic [5:0] a);
      logic [7:0] r;
      int         line;
      r    = 8'hff;
      line = exp_line();
      case (a)
         `REG_CTRL1: begin
            r[2:0] = m_ysc;
            r[4]   = m_den;
            r[7]   = line[8];
         end
         `REG_RASTER:
            r = line[7:0];
         `REG_IRQ_STATUS: begin
            r[7] = m_irq;
            r[0] = m_irst;
         end
         `REG_IRQ_ENABLE:
            r[0] = m_erst;
         default:
            r = 8'hff;
      endcase
      return r;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at t=%0t: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // model advances on the same edge as the DUT using pre-edge values
   always @(posedge clk_dot4x) begin : model
      int   x;
      int   line;
      logic phi_end;
      logic ba_m;
      logic wr;
      logic clr;
      logic irst_n;
      started = 1'b1;
      if (rst) begin
         n         = 0;
         m_ysc     = '0;
         m_den     = 1'b0;
         m_cmp     = '0;
         m_erst    = 1'b0;
         m_matched = 1'b0;
         m_irst    = 1'b0;
         m_irq     = 1'b0;
         m_allow   = 1'b0;
         m_lowcnt  = 0;
         m_aec     = 1'b0;
         m_dbo     = 8'hff;
      end else begin
         x       = exp_x();
         line    = exp_line();
         // last clock of pixel 7 ends phi high
         phi_end = (n % `TICKS_PER_DOT == `TICKS_PER_DOT - 1) && (x % 8 == 7);
         ba_m    = exp_ba();
         wr      = phi_end && !ce && !rw;
         clr     = wr && adi == `REG_IRQ_STATUS && dbi[0];
         m_dbo   = (!ce && rw) ? read_model(adi) : 8'hff;
         // vic keeps phi high once ba has been low for the grace phases
         m_aec   = x[2] && !(!ba_m && m_lowcnt >= `AEC_GRACE_PHASES);
         irst_n  = !clr && (m_irst || (line == m_cmp && !m_matched));
         m_matched = (line == m_cmp);
         m_irq     = irst_n && m_erst;
         m_irst    = irst_n;
         if (line == `BADLINE_FIRST && m_den)
            m_allow = 1'b1;
         if (line == `BADLINE_LAST)
            m_allow = 1'b0;
         if (phi_end)
            m_lowcnt = ba_m ? 0 :
                       (m_lowcnt < `AEC_GRACE_PHASES ? m_lowcnt + 1 : m_lowcnt);
         if (wr) begin
            case (adi)
               `REG_CTRL1: begin
                  m_ysc    = dbi[2:0];
                  m_den    = dbi[4];
                  m_cmp[8] = dbi[7];
               end
               `REG_RASTER:     m_cmp[7:0] = dbi;
               `REG_IRQ_ENABLE: m_erst = dbi[0];
               default:         m_erst = m_erst;
            endcase
         end
         n = n + 1;
      end
   end

   // outputs compared mid-cycle
   always @(negedge clk_dot4x) begin : compare
      logic wdb;
      if (started) begin
         wdb = m_aec && rw && !ce;
         check(raster_x, exp_x(), "raster_x");
         check(raster_line, exp_line(), "raster_line");
         check(clk_phi, (exp_x() / 4) % 2, "clk_phi");
         check(irq, m_irq, "irq");
         check(ba, exp_ba(), "ba");
         check(aec, m_aec, "aec");
         check(vic_write_db, wdb, "vic_write_db");
         check(vic_write_ab, !m_aec, "vic_write_ab");
         check(ls245_data_dir, !wdb, "ls245_data_dir");
         check(dbo, m_dbo, "dbo");
         if (!ba && n < FRAME_CLOCKS)
            ba_lo0++;
         else if (!ba)
            ba_lo1++;
      end
   end

   always @(posedge clk_dot4x) begin
      cyc_cnt = cyc_cnt + 1;
      if (cyc_cnt >= LIMIT_CLOCKS) begin
         $display("timeout: run did not finish within %0d clocks", LIMIT_CLOCKS);
         $display("Simulation FAILED");
         $fatal(1);
      end
   end

   // one clock of random reads
   // rw is random only on unused addresses
   task automatic idle_step();
      logic [31:0] r;
      r = next_rand();
      @(posedge clk_dot4x);
      ce  <= r[20];
      rw  <= 1'b1;
      dbi <= r[31:24];
      case (r[2:0])
         3'd0: adi <= `REG_CTRL1;
         3'd1: adi <= `REG_RASTER;
         3'd2: adi <= `REG_IRQ_STATUS;
         3'd3: adi <= `REG_IRQ_ENABLE;
         default: begin
            adi <= {1'b1, r[12:8]};
            rw  <= r[16];
         end
      endcase
      @(negedge clk_dot4x);
   endtask

   // held for a whole phi cycle so one phi_end falls inside
   task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
      @(posedge clk_dot4x);
      adi <= a;
      dbi <= d;
      ce  <= 1'b0;
      rw  <= 1'b0;
      repeat (PHI_CLOCKS) @(posedge clk_dot4x);
      ce <= 1'b1;
      rw <= 1'b1;
      @(negedge clk_dot4x);
   endtask

   // read status until irst shows
   // first readback is valid after two clocks
   task automatic poll_irst();
      @(posedge clk_dot4x);
      adi <= `REG_IRQ_STATUS;
      ce  <= 1'b0;
      rw  <= 1'b1;
      repeat (2) @(negedge clk_dot4x);
      while (dbo[0] !== 1'b1)
         @(negedge clk_dot4x);
   endtask

   initial begin
      logic [2:0] ysc;
      logic [7:0] en;
      int         la;
      int         lb;
      int         lc;
      clk_dot4x = 1'b0;
      rst       = 1'b1;
      chip      = CHIP6567R56A;
      adi       = '0;
      dbi       = '0;
      ce        = 1'b1;
      rw        = 1'b1;
      repeat (5) @(posedge clk_dot4x);
      rst <= 1'b0;

      // frame 0 with den set so bad lines follow yscroll
      ysc = 3'(next_rand());
      bus_write(`REG_CTRL1, {3'b000, 1'b1, 1'b0, ysc});
      la = 60 + next_rand() % 100;
      bus_write(`REG_RASTER, 8'(la));
      // line 0 matched compare 0 after reset
      bus_write(`REG_IRQ_STATUS, 8'h01);
      en = 8'(next_rand());
      bus_write(`REG_IRQ_ENABLE, {en[7:1], 1'b1});
      while (irq !== 1'b1)
         idle_step();
      check(raster_line, la, "line of enabled raster irq");
      bus_write(`REG_IRQ_STATUS, 8'h01);
      check(irq, 0, "irq after status clear");
      // no second trigger within the same line
      repeat (next_rand() % 256) idle_step();

      // masked match sets irst only
      en = 8'(next_rand());
      bus_write(`REG_IRQ_ENABLE, {en[7:1], 1'b0});
      lb = 170 + next_rand() % 60;
      bus_write(`REG_RASTER, 8'(lb));
      poll_irst();
      check(irq, 0, "irq with erst clear");
      check(raster_line, lb, "line of masked raster match");
      repeat (next_rand() % 200) idle_step();
      bus_write(`REG_IRQ_ENABLE, 8'h01);
      idle_step();
      check(irq, 1, "irq once erst is set");
      bus_write(`REG_IRQ_STATUS, 8'h01);
      check(irq, 0, "irq after second clear");

      // compare line above 255 through ctrl bit 7
      lc = 256 + next_rand() % 6;
      bus_write(`REG_CTRL1, {1'b1, 2'b00, 1'b1, 1'b0, ysc});
      bus_write(`REG_RASTER, 8'(lc));
      while (irq !== 1'b1)
         idle_step();
      check(raster_line, lc, "line of high raster irq");
      bus_write(`REG_IRQ_STATUS, 8'h01);

      // den clear for frame 1
      bus_write(`REG_CTRL1, {3'b000, 1'b0, 1'b0, 3'(next_rand())});
      while (n < PLAN_CLOCKS)
         idle_step();
      check(ba_lo0 > 0, 1, "ba low during frame 0 bad lines");
      check(ba_lo1, 0, "ba low clocks in frame 1 with den clear");

      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+.
vic_pkg.sv
raster_timing.sv
raster_irq.sv
badline_detect.sv
bus_arbiter.sv
host_regs.sv
vic_core.sv
vic_core_asserts.sv
tb_vic_core.sv

/* vic_core.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module vic_core import vic_pkg::*; (
   input  chip_type               chip,
   input  logic                   rst,
   input  logic                   clk_dot4x,
   input  logic [5:0]             adi,
   input  logic [7:0]             dbi,
   input  logic                   ce,
   input  logic                   rw,
   output logic                   clk_phi,
   output logic [`RASTER_X_W-1:0] raster_x,
   output logic [`RASTER_Y_W-1:0] raster_line,
   output logic [7:0]             dbo,
   output logic                   irq,
   output logic                   ba,
   output logic                   aec,
   output logic                   vic_write_db,
   output logic                   vic_write_ab,
   output logic                   ls245_data_dir
);

   raster_pos_t pos;
   vic_ctrl_t   ctrl;
   irq_state_t  irq_st;
   logic        phi_end;
   logic        irst_clr;
   // active low bus request from the bad-line unit
   logic        ba_req;

   // beam counters and phi
   raster_timing u_raster_timing (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .pos       (pos),
      .clk_phi   (clk_phi),
      .phi_end   (phi_end)
   );

   // raster compare latch
   raster_irq u_raster_irq (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .ctrl      (ctrl),
      .irst_clr  (irst_clr),
      .irq_st    (irq_st)
   );

   badline_detect u_badline_detect (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .pos       (pos),
      .ctrl      (ctrl),
      .ba_req    (ba_req)
   );

   // ba to aec handover and buffer directions
   bus_arbiter u_bus_arbiter (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phi_end        (phi_end),
      .ba_req         (ba_req),
      .ce             (ce),
      .rw             (rw),
      .ba             (ba),
      .aec            (aec),
      .vic_write_db   (vic_write_db),
      .vic_write_ab   (vic_write_ab),
      .ls245_data_dir (ls245_data_dir)
   );

   host_regs u_host_regs (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phi_end   (phi_end),
      .ce        (ce),
      .rw        (rw),
      .adi       (adi),
      .dbi       (dbi),
      .pos       (pos),
      .irq_st    (irq_st),
      .ctrl      (ctrl),
      .irst_clr  (irst_clr),
      .dbo       (dbo)
   );

   assign raster_x    = pos.x;
   assign raster_line = pos.line;
   assign irq         = irq_st.irq;

endmodule

/* vic_core_asserts.sv */
`timescale 1ns/1ps

`include "vic_defines.svh"

module vic_core_asserts (
   input logic                   clk_dot4x,
   input logic                   rst,
   input logic                   clk_phi,
   input logic                   aec,
   input logic                   ba,
   input logic [`RASTER_Y_W-1:0] raster_line,
   input logic                   irq,
   input logic                   erst
);

   // aec is phi delayed one clock, so it needs phi high before it
   aec_after_phi: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      aec |-> $past(clk_phi)
   ) else $error("aec high although clk_phi was low on the previous clock");

   // bad lines only inside the display window
   ba_in_window: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      !ba |-> (raster_line >= `BADLINE_FIRST && raster_line < `BADLINE_LAST)
   ) else $error("ba low outside lines 48 to 247");

   // a masked raster match must not reach irq
   irq_needs_erst: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      $rose(irq) |-> $past(erst)
   ) else $error("irq rose while erst was clear");

endmodule

/* vic_defines.svh */
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// raster counter widths
`define RASTER_X_W 10
`define RASTER_Y_W 9

// dot4x clock ticks per pixel
`define TICKS_PER_DOT 4

// bad lines may only occur in this line range
// first line inclusive, last line exclusive
`define BADLINE_FIRST 48
`define BADLINE_LAST 248

// character fetch ba window in 8-pixel cycles, both ends inclusive
`define CHARS_BA_FIRST_CYCLE 12
`define CHARS_BA_LAST_CYCLE 54

// phi-high phases the cpu keeps aec after ba falls
`define AEC_GRACE_PHASES 3

// host register addresses
// vertical control, raster compare, irq status, irq enable
`define REG_CTRL1 6'h11
`define REG_RASTER 6'h12
`define REG_IRQ_STATUS 6'h19
`define REG_IRQ_ENABLE 6'h1a

`endif

/* vic_pkg.sv */
`include "vic_defines.svh"

package vic_pkg;

   // chip variants, unused code runs as the pal part
   typedef enum logic [1:0] {
      CHIP6567R8,
      CHIP6567R56A,
      CHIP6569,
      CHIPUNUSED
   } chip_type;

   // current beam position
   // x counts pixels within the line, line counts raster lines
   typedef struct packed {
      logic [`RASTER_Y_W-1:0] line;
      logic [`RASTER_X_W-1:0] x;
   } raster_pos_t;

   // control fields written by the host
   // raster_cmp bit 8 comes from the vertical control register
   typedef struct packed {
      logic [2:0]             yscroll;
      logic                   den;
      logic [`RASTER_Y_W-1:0] raster_cmp;
      logic                   erst;
   } vic_ctrl_t;

   // raster interrupt state
   // irst is the raw latch, irq is the enabled output level
   typedef struct packed {
      logic irst;
      logic irq;
   } irq_state_t;

   // each phi cycle is 8 pixels, so the cycle number is x / 8
   function automatic logic [`RASTER_X_W-4:0] cycle_num(input raster_pos_t p);
      return p.x[`RASTER_X_W-1:3];
   endfunction

endpackage
